// ==== filelist.f ====
src/tetris_pkg.sv
src/input_strobe.sv
src/piece_shape_rom.sv
src/board_collision.sv
src/board_store.sv
src/tetris_game_fsm.sv
src/tetris_top.sv
testbench/tetris_assertions.sv
testbench/tetris_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the tetris testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tetris_tb \
    -o tetris_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/tetris_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    echo "Simulation reported failure, see sim.log"
    exit 1
fi

echo "Simulation passed"
exit 0

// ==== testbench/tetris_tb.sv ====
`default_nettype none

module tetris_tb;
    import tetris_pkg::*;

    // Button bits in struct order: left, right, cw, ccw, start, tick
    localparam buttons_t BTN_LEFT  = 6'b100000;
    localparam buttons_t BTN_RIGHT = 6'b010000;
    localparam buttons_t BTN_CW    = 6'b001000;
    localparam buttons_t BTN_CCW   = 6'b000100;
    localparam buttons_t BTN_START = 6'b000010;
    localparam buttons_t BTN_TICK  = 6'b000001;

    logic     clk;
    logic     reset;
    buttons_t buttons;
    board_t   display;
    score_t   score;
    logic     gameover;

    board_t exp_board;
    int     exp_score;
    int     piece_num;
    int     checks;
    int     errors;
    int     timeouts;
    logic   run_done;
    logic   freeze_on;
    board_t frozen;

    tetris_top #(
        .ROWS      (BOARD_ROWS),
        .COLS      (BOARD_COLS),
        .SPAWN_COL (SPAWN_X)
    ) uut (
        .clk        (clk),
        .reset      (reset),
        .buttons_i  (buttons),
        .display_o  (display),
        .score_o    (score),
        .gameover_o (gameover)
    );

    always #50 clk = ~clk;

    // ========================================================================
    // Reference model
    // ========================================================================
    // Box bit r*4 + c, each nibble holds one box row with column 0 as LSB
    function automatic pattern_t pattern_of(input int code);
        case (code)
            0:       return 16'h1111;
            7:       return 16'h000F;
            1:       return 16'h0033;
            2:       return 16'h0036;
            3:       return 16'h0063;
            4:       return 16'h0071;
            5:       return 16'h0074;
            15:      return 16'h0223;
            6:       return 16'h0072;
            default: return 16'h0000;
        endcase
    endfunction

    // Rotation successors for the pieces that the test turns
    function automatic int successor(input int code, input bit ccw);
        case (code)
            0:       return 7;
            7:       return 0;
            5:       return ccw ? 15 : 13;
            default: return code;
        endcase
    endfunction

    function automatic board_t place(input pattern_t p, input int row, input int col);
        board_t b;
        b = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (p[r*4 + c] && row + r < BOARD_ROWS && col + c < BOARD_COLS) begin
                    b[(row + r)*BOARD_COLS + col + c] = 1'b1;
                end
            end
        end
        return b;
    endfunction

    function automatic bit fits(input pattern_t p, input int row, input int col,
                                input board_t b);
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (p[r*4 + c]) begin
                    if (row + r >= BOARD_ROWS || col + c >= BOARD_COLS) return 1'b0;
                    if (b[(row + r)*BOARD_COLS + col + c]) return 1'b0;
                end
            end
        end
        return 1'b1;
    endfunction

    // Drops a piece, ORs it in and collapses full rows; returns rows cleared
    function automatic int predict_drop(input pattern_t p, input int col,
                                        input board_t b, output board_t nb,
                                        output int land);
        int cleared;
        int r;
        cleared = 0;
        land    = 0;
        while (land < BOARD_ROWS - 1 && fits(p, land + 1, col, b)) land++;
        nb = b | place(p, land, col);
        r  = BOARD_ROWS - 1;
        while (r >= 0) begin
            if (&nb[r*BOARD_COLS +: BOARD_COLS]) begin
                for (int k = r; k > 0; k--) begin
                    nb[k*BOARD_COLS +: BOARD_COLS] = nb[(k-1)*BOARD_COLS +: BOARD_COLS];
                end
                nb[BOARD_COLS-1:0] = '0;
                cleared++;
            end else begin
                r--;
            end
        end
        return cleared;
    endfunction

    // ========================================================================
    // Checks and waits
    // ========================================================================
    task automatic check_value(input string name, input logic [199:0] got,
                               input logic [199:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic abort_run(input string what);
        timeouts++;
        $display("Timeout: %s", what);
        run_done = 1'b1;
        forever @(posedge clk);
    endtask

    // One-cycle press, then time for sync, strobe and the FSM step
    task automatic press(input buttons_t b);
        @(posedge clk);
        #10 buttons = b;
        @(posedge clk);
        #10 buttons = '0;
        repeat (4) @(posedge clk);
        #10;
    endtask

    task automatic wait_next_piece();
        int cnt;
        cnt = 0;
        while (!(uut.u_fsm.state == FALLING || gameover) && cnt < 100) begin
            @(posedge clk);
            #10;
            cnt++;
        end
        if (!(uut.u_fsm.state == FALLING || gameover)) abort_run("no new piece appeared");
    endtask

    task automatic tick_until_locked();
        int ticks;
        ticks = 0;
        while (uut.u_fsm.state == FALLING && ticks < 40) begin
            press(BTN_TICK);
            ticks++;
        end
        if (uut.u_fsm.state == FALLING) abort_run("piece never locked under drop ticks");
    endtask

    task automatic move_piece(input pattern_t p, inout int col, input int target);
        while (col != target) begin
            if (target < col) begin
                press(BTN_LEFT);
                col--;
            end else begin
                press(BTN_RIGHT);
                col++;
            end
            check_value("display_o", display, exp_board | place(p, 0, col));
        end
    endtask

    task automatic drop_checked(input pattern_t p, input int col);
        board_t nb;
        int     land;
        int     cleared;
        cleared = predict_drop(p, col, exp_board, nb, land);
        tick_until_locked();
        wait_next_piece();
        piece_num++;
        check_value("gameover_o", 200'(gameover), 200'(land == 0));
        if (land == 0) begin
            // A lock in row 0 ends the game before any clearing
            exp_board = exp_board | place(p, land, col);
            check_value("display_o", display, exp_board);
        end else begin
            exp_board = nb;
            exp_score += cleared;
            check_value("display_o", display,
                        nb | place(pattern_of(piece_num % 7), 0, SPAWN_X));
        end
        check_value("score_o", 200'(score), 200'(exp_score));
    endtask

    // Display must stay put once the game is over
    always @(negedge clk) begin
        if (freeze_on) check_value("display_o", display, frozen);
    end

    // ========================================================================
    // Stimulus
    // ========================================================================
    initial begin
        int col;
        int code;
        int n;
        pattern_t p;
        clk       = 1'b0;
        reset     = 1'b1;
        buttons   = '0;
        exp_board = '0;
        exp_score = 0;
        piece_num = 0;
        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        run_done  = 1'b0;
        freeze_on = 1'b0;
        frozen    = '0;
        void'($urandom(69634));
        repeat (5) @(posedge clk);
        #10 reset = 1'b0;
        @(posedge clk);
        #10;
        check_value("display_o", display, '0);
        check_value("score_o", 200'(score), '0);
        check_value("gameover_o", 200'(gameover), '0);

        press(BTN_START);
        wait_next_piece();
        col = SPAWN_X;
        p   = pattern_of(0);
        check_value("display_o", display, place(p, 0, col));

        // Walk into both walls
        for (int i = 0; i < 5; i++) begin
            press(BTN_LEFT);
            if (col > 0) col--;
            check_value("display_o", display, place(p, 0, col));
        end
        for (int i = 0; i < 11; i++) begin
            press(BTN_RIGHT);
            if (col < BOARD_COLS - 1) col++;
            check_value("display_o", display, place(p, 0, col));
        end

        // Flat I does not fit at the right wall
        press(BTN_CW);
        check_value("display_o", display, place(p, 0, col));
        move_piece(p, col, 6);
        press(BTN_CW);
        code = successor(0, 1'b0);
        p    = pattern_of(code);
        check_value("display_o", display, place(p, 0, col));
        drop_checked(p, col);

        // O, S, Z and J pile up so that L completes the bottom row
        col = SPAWN_X;
        move_piece(pattern_of(1), col, 0);
        drop_checked(pattern_of(1), col);
        col = SPAWN_X;
        move_piece(pattern_of(2), col, 7);
        drop_checked(pattern_of(2), col);
        col = SPAWN_X;
        move_piece(pattern_of(3), col, 7);
        drop_checked(pattern_of(3), col);
        col = SPAWN_X;
        move_piece(pattern_of(4), col, 2);
        drop_checked(pattern_of(4), col);
        col = SPAWN_X;
        press(BTN_CCW);
        code = successor(5, 1'b1);
        p    = pattern_of(code);
        check_value("display_o", display, exp_board | place(p, 0, col));
        move_piece(p, col, 4);
        drop_checked(p, col);
        check_value("score_o", 200'(score), 200'(1));

        // Two pieces at random columns
        col = SPAWN_X;
        move_piece(pattern_of(6), col, int'($urandom % 8));
        drop_checked(pattern_of(6), col);
        col = SPAWN_X;
        move_piece(pattern_of(0), col, int'($urandom % 10));
        drop_checked(pattern_of(0), col);

        // Stack at the spawn column until the top is reached
        n = 0;
        while (!gameover && n < 40) begin
            drop_checked(pattern_of(piece_num % 7), SPAWN_X);
            n++;
        end
        if (!gameover) begin
            errors++;
            $display("Error: gameover_o never rose while stacking pieces");
        end

        frozen    = display;
        freeze_on = 1'b1;
        press(BTN_LEFT);
        press(BTN_RIGHT);
        press(BTN_CW);
        press(BTN_START);
        press(BTN_TICK);
        freeze_on = 1'b0;
        check_value("gameover_o", 200'(gameover), 200'(1));
        run_done = 1'b1;
    end

    initial begin
        #(100 * 30000);
        timeouts++;
        $display("Timeout: simulation time limit reached");
        run_done = 1'b1;
    end

    initial begin
        wait (run_done);
        #1;
        $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tetris_assertions.sv ====
`default_nettype none

module tetris_assertions (
    input logic clk,
    input logic reset,
    input logic req_i,
    input logic ack_i,
    input logic lock_i
);
    // Ack may only rise while a request is pending
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(ack_i) |-> req_i)
        else $error("clear ack rose without a request");

    // Request stays up until it is acknowledged
    req_holds: assert property (@(posedge clk) disable iff (reset)
        (req_i && !ack_i) |=> req_i)
        else $error("clear request dropped before ack");

    lock_one_cycle: assert property (@(posedge clk) disable iff (reset)
        lock_i |=> !lock_i)
        else $error("lock lasted more than one cycle");

endmodule

bind tetris_game_fsm tetris_assertions u_fsm_checks (
    .clk    (clk),
    .reset  (reset),
    .req_i  (clear_req_o),
    .ack_i  (clear_ack_i),
    .lock_i (lock_o)
);

bind board_store tetris_assertions u_store_checks (
    .clk    (clk),
    .reset  (reset),
    .req_i  (clear_req_i),
    .ack_i  (clear_ack_o),
    .lock_i (lock_i)
);

`default_nettype wire

// ==== src/tetris_top.sv ====
`default_nettype none

module tetris_top #(
    parameter int ROWS      = tetris_pkg::BOARD_ROWS,
    parameter int COLS      = tetris_pkg::BOARD_COLS,
    parameter int SPAWN_COL = tetris_pkg::SPAWN_X
) (
    input  logic                 clk,
    input  logic                 reset,
    input  tetris_pkg::buttons_t buttons_i,
    output tetris_pkg::board_t   display_o,
    output tetris_pkg::score_t   score_o,
    output logic                 gameover_o
);
    import tetris_pkg::*;

    buttons_t    strobes;
    piece_pos_t  pos;
    shape_code_t code;
    shape_code_t cand_code;
    pattern_t    pattern;
    pattern_t    cand_pattern;
    board_t      falling;
    board_t      stored;
    contact_t    contact;
    logic        lock;
    logic        clear_req;
    logic        clear_ack;

    input_strobe u_strobe (
        .clk      (clk),
        .reset    (reset),
        .raw_i    (buttons_i),
        .strobe_o (strobes)
    );

    tetris_game_fsm #(
        .COLS      (COLS),
        .SPAWN_COL (SPAWN_COL)
    ) u_fsm (
        .clk         (clk),
        .reset       (reset),
        .strobe_i    (strobes),
        .contact_i   (contact),
        .board_i     (stored),
        .pos_o       (pos),
        .code_o      (code),
        .cand_code_o (cand_code),
        .lock_o      (lock),
        .clear_req_o (clear_req),
        .clear_ack_i (clear_ack),
        .gameover_o  (gameover_o)
    );

    // Current piece and the proposed rotation
    piece_shape_rom u_rom_cur (
        .code_i     (code),
        .pattern_o  (pattern),
        .cw_code_o  (),
        .ccw_code_o ()
    );

    piece_shape_rom u_rom_cand (
        .code_i     (cand_code),
        .pattern_o  (cand_pattern),
        .cw_code_o  (),
        .ccw_code_o ()
    );

    board_collision #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_collision (
        .pos_i          (pos),
        .pattern_i      (pattern),
        .cand_pattern_i (cand_pattern),
        .board_i        (stored),
        .falling_o      (falling),
        .contact_o      (contact)
    );

    board_store #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_store (
        .clk         (clk),
        .reset       (reset),
        .lock_i      (lock),
        .falling_i   (falling),
        .clear_req_i (clear_req),
        .clear_ack_o (clear_ack),
        .board_o     (stored),
        .score_o     (score_o)
    );

    assign display_o = stored | falling;

endmodule

`default_nettype wire

// ==== src/tetris_game_fsm.sv ====
`default_nettype none

module tetris_game_fsm #(
    parameter int COLS      = tetris_pkg::BOARD_COLS,
    parameter int SPAWN_COL = tetris_pkg::SPAWN_X
) (
    input  logic                    clk,
    input  logic                    reset,
    input  tetris_pkg::buttons_t    strobe_i,
    input  tetris_pkg::contact_t    contact_i,
    input  tetris_pkg::board_t      board_i,
    output tetris_pkg::piece_pos_t  pos_o,
    output tetris_pkg::shape_code_t code_o,
    output tetris_pkg::shape_code_t cand_code_o,
    output logic                    lock_o,
    output logic                    clear_req_o,
    input  logic                    clear_ack_i,
    output logic                    gameover_o
);
    import tetris_pkg::*;

    game_state_t state;
    game_state_t next_state;
    piece_pos_t  pos_q;
    shape_code_t code_q;
    logic [2:0]  spawn_cnt;
    logic        grace;
    logic        rot_ccw_q;
    logic        ack_seen;
    logic        rot_req;
    logic        top_hit;

    assign rot_req = strobe_i.rot_cw | strobe_i.rot_ccw;

    // Every box has a cell in its top row, so a lock at row 0 reaches the top
    assign top_hit = (pos_q.row == '0) || (|board_i[COLS-1:0]);

    always_comb begin
        next_state = state;
        case (state)
            IDLE:     if (strobe_i.start) next_state = SPAWN;
            SPAWN:    next_state = FALLING;
            FALLING: begin
                if (strobe_i.drop_tick && contact_i.floor && grace) begin
                    next_state = LOCK;
                end else if (rot_req && contact_i.rot_fits) begin
                    next_state = ROTATE;
                end
            end
            ROTATE:   next_state = FALLING;
            LOCK:     next_state = top_hit ? GAMEOVER : CLEAR;
            CLEAR:    if (ack_seen && !clear_ack_i) next_state = SPAWN;
            GAMEOVER: next_state = GAMEOVER;
            default:  next_state = IDLE;
        endcase
    end

    // =========================================================================
    // Piece registers
    // =========================================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            pos_q     <= '0;
            code_q    <= SHAPE_NONE;
            spawn_cnt <= '0;
            grace     <= 1'b0;
            rot_ccw_q <= 1'b0;
        end else begin
            state <= next_state;
            case (state)
                SPAWN: begin
                    pos_q.row <= '0;
                    pos_q.col <= col_idx_t'(SPAWN_COL);
                    code_q    <= {2'b00, spawn_cnt};
                    spawn_cnt <= (spawn_cnt == 3'd6) ? 3'd0 : spawn_cnt + 3'd1;
                    grace     <= 1'b0;
                end
                FALLING: begin
                    // Grace starts on a tick in contact, lost when contact ends
                    if (!contact_i.floor) begin
                        grace <= 1'b0;
                    end else if (strobe_i.drop_tick) begin
                        grace <= 1'b1;
                    end
                    if (next_state == ROTATE) begin
                        rot_ccw_q <= strobe_i.rot_ccw;
                    end
                    if (next_state == FALLING) begin
                        if (strobe_i.drop_tick) begin
                            if (!contact_i.floor) pos_q.row <= pos_q.row + 5'd1;
                        end else if (strobe_i.move_left && !contact_i.left) begin
                            pos_q.col <= pos_q.col - 4'd1;
                        end else if (strobe_i.move_right && !contact_i.right) begin
                            pos_q.col <= pos_q.col + 4'd1;
                        end
                    end
                end
                ROTATE:  code_q <= cand_code_o;
                // Piece now lives in the store
                LOCK:    code_q <= SHAPE_NONE;
                default: code_q <= code_q;
            endcase
        end
    end

    // Req side of the clear handshake
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_seen <= 1'b0;
        end else if (state != CLEAR) begin
            ack_seen <= 1'b0;
        end else if (clear_ack_i) begin
            ack_seen <= 1'b1;
        end
    end

    assign cand_code_o = next_orient(code_q, (state == ROTATE) ? rot_ccw_q : strobe_i.rot_ccw);
    assign pos_o       = pos_q;
    assign code_o      = code_q;
    assign lock_o      = (state == LOCK);
    assign clear_req_o = (state == CLEAR) && !ack_seen;
    assign gameover_o  = (state == GAMEOVER);

endmodule

`default_nettype wire

// ==== src/board_store.sv ====
`default_nettype none

module board_store #(
    parameter int ROWS = tetris_pkg::BOARD_ROWS,
    parameter int COLS = tetris_pkg::BOARD_COLS
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               lock_i,
    input  tetris_pkg::board_t falling_i,
    input  logic               clear_req_i,
    output logic               clear_ack_o,
    output tetris_pkg::board_t board_o,
    output tetris_pkg::score_t score_o
);
    import tetris_pkg::*;

    board_t   board_q;
    board_t   shifted;
    score_t   score_q;
    row_idx_t full_row;
    logic     full_found;
    logic     ack_q;

    // Lowest full row wins, since the scan runs top to bottom
    always_comb begin
        full_found = 1'b0;
        full_row   = '0;
        for (int r = 0; r < ROWS; r++) begin
            if (&board_q[r*COLS +: COLS]) begin
                full_found = 1'b1;
                full_row   = row_idx_t'(r);
            end
        end
    end

    // Rows at and above the full row move down one step
    always_comb begin
        shifted           = board_q;
        shifted[COLS-1:0] = '0;
        for (int r = 1; r < ROWS; r++) begin
            if (row_idx_t'(r) <= full_row) begin
                shifted[r*COLS +: COLS] = board_q[(r-1)*COLS +: COLS];
            end
        end
    end

    // =========================================================================
    // Storage, clearing and the ack side of the handshake
    // =========================================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            board_q <= '0;
            score_q <= '0;
            ack_q   <= 1'b0;
        end else begin
            if (lock_i) begin
                board_q <= board_q | falling_i;
            end
            if (clear_req_i && !ack_q) begin
                if (full_found) begin
                    board_q <= shifted;
                    score_q <= score_q + score_t'(1);
                end else begin
                    ack_q <= 1'b1;
                end
            end else if (!clear_req_i && ack_q) begin
                ack_q <= 1'b0;
            end
        end
    end

    assign clear_ack_o = ack_q;
    assign board_o     = board_q;
    assign score_o     = score_q;

endmodule

`default_nettype wire

// ==== src/board_collision.sv ====
`default_nettype none

module board_collision #(
    parameter int ROWS = tetris_pkg::BOARD_ROWS,
    parameter int COLS = tetris_pkg::BOARD_COLS
) (
    input  tetris_pkg::piece_pos_t pos_i,
    input  tetris_pkg::pattern_t   pattern_i,
    input  tetris_pkg::pattern_t   cand_pattern_i,
    input  tetris_pkg::board_t     board_i,
    output tetris_pkg::board_t     falling_o,
    output tetris_pkg::contact_t   contact_o
);
    import tetris_pkg::*;

    always_comb begin
        int ar;
        int ac;
        falling_o          = '0;
        contact_o          = '0;
        contact_o.rot_fits = 1'b1;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                ar = int'(pos_i.row) + r;
                ac = int'(pos_i.col) + c;

                // Current piece: draw it and look at its neighbours
                if (pattern_i[r*4 + c]) begin
                    if (ar < ROWS && ac < COLS) begin
                        falling_o[ar*COLS + ac] = 1'b1;
                    end
                    if (ar + 1 >= ROWS) begin
                        contact_o.floor = 1'b1;
                    end else if (ac < COLS && board_i[(ar+1)*COLS + ac]) begin
                        contact_o.floor = 1'b1;
                    end
                    if (ac == 0) begin
                        contact_o.left = 1'b1;
                    end else if (ar < ROWS && ac <= COLS && board_i[ar*COLS + ac - 1]) begin
                        contact_o.left = 1'b1;
                    end
                    if (ac + 1 >= COLS) begin
                        contact_o.right = 1'b1;
                    end else if (ar < ROWS && board_i[ar*COLS + ac + 1]) begin
                        contact_o.right = 1'b1;
                    end
                end

                // Candidate orientation must stay inside and on empty cells
                if (cand_pattern_i[r*4 + c]) begin
                    if (ar >= ROWS || ac >= COLS) begin
                        contact_o.rot_fits = 1'b0;
                    end else if (board_i[ar*COLS + ac]) begin
                        contact_o.rot_fits = 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/piece_shape_rom.sv ====
`default_nettype none

module piece_shape_rom (
    input  tetris_pkg::shape_code_t code_i,
    output tetris_pkg::pattern_t    pattern_o,
    output tetris_pkg::shape_code_t cw_code_o,
    output tetris_pkg::shape_code_t ccw_code_o
);
    import tetris_pkg::*;

    // Rows given left to right, so the MSB of each nibble is box column 0
    function automatic pattern_t box(input logic [3:0] r0, input logic [3:0] r1,
                                     input logic [3:0] r2, input logic [3:0] r3);
        logic [3:0][3:0] rows;
        pattern_t        p;
        rows = {r3, r2, r1, r0};
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                p[r*4 + c] = rows[r][3 - c];
            end
        end
        return p;
    endfunction

    always_comb begin
        case (code_i)
            5'd0:    pattern_o = box(4'b1000, 4'b1000, 4'b1000, 4'b1000);
            5'd7:    pattern_o = box(4'b1111, 4'b0000, 4'b0000, 4'b0000);
            5'd1:    pattern_o = box(4'b1100, 4'b1100, 4'b0000, 4'b0000);
            5'd2:    pattern_o = box(4'b0110, 4'b1100, 4'b0000, 4'b0000);
            5'd9:    pattern_o = box(4'b1000, 4'b1100, 4'b0100, 4'b0000);
            5'd3:    pattern_o = box(4'b1100, 4'b0110, 4'b0000, 4'b0000);
            5'd8:    pattern_o = box(4'b0100, 4'b1100, 4'b1000, 4'b0000);
            // J
            5'd4:    pattern_o = box(4'b1000, 4'b1110, 4'b0000, 4'b0000);
            5'd10:   pattern_o = box(4'b1100, 4'b1000, 4'b1000, 4'b0000);
            5'd11:   pattern_o = box(4'b1110, 4'b0010, 4'b0000, 4'b0000);
            5'd12:   pattern_o = box(4'b0100, 4'b0100, 4'b1100, 4'b0000);
            // L
            5'd5:    pattern_o = box(4'b0010, 4'b1110, 4'b0000, 4'b0000);
            5'd13:   pattern_o = box(4'b1000, 4'b1000, 4'b1100, 4'b0000);
            5'd14:   pattern_o = box(4'b1110, 4'b1000, 4'b0000, 4'b0000);
            5'd15:   pattern_o = box(4'b1100, 4'b0100, 4'b0100, 4'b0000);
            // T
            5'd6:    pattern_o = box(4'b0100, 4'b1110, 4'b0000, 4'b0000);
            5'd18:   pattern_o = box(4'b1000, 4'b1100, 4'b1000, 4'b0000);
            5'd17:   pattern_o = box(4'b1110, 4'b0100, 4'b0000, 4'b0000);
            5'd16:   pattern_o = box(4'b0100, 4'b1100, 4'b0100, 4'b0000);
            default: pattern_o = '0;
        endcase
    end

    // O maps to itself in both directions
    assign cw_code_o  = next_orient(code_i, 1'b0);
    assign ccw_code_o = next_orient(code_i, 1'b1);

endmodule

`default_nettype wire

// ==== src/input_strobe.sv ====
`default_nettype none

module input_strobe (
    input  logic                 clk,
    input  logic                 reset,
    input  tetris_pkg::buttons_t raw_i,
    output tetris_pkg::buttons_t strobe_o
);
    import tetris_pkg::*;

    buttons_t sync_a;
    buttons_t sync_b;
    buttons_t level_q;

    // Two flops against metastability, a third holds the last level
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_a  <= '0;
            sync_b  <= '0;
            level_q <= '0;
        end else begin
            sync_a  <= raw_i;
            sync_b  <= sync_a;
            level_q <= sync_b;
        end
    end

    // One-cycle pulse per rising edge, field by field
    assign strobe_o = buttons_t'(sync_b & ~level_q);

endmodule

`default_nettype wire

// ==== src/tetris_pkg.sv ====
`default_nettype none

package tetris_pkg;

    // =========================================================================
    // Board geometry
    // =========================================================================
    localparam int BOARD_ROWS = 20;
    localparam int BOARD_COLS = 10;
    localparam int SPAWN_X    = 3;

    typedef logic [4:0] row_idx_t;
    typedef logic [3:0] col_idx_t;
    typedef logic [4:0] shape_code_t;

    // Cell (r, c) sits at bit r*BOARD_COLS + c, row 0 on top
    typedef logic [BOARD_ROWS*BOARD_COLS-1:0] board_t;

    // Box cell (r, c) sits at bit r*4 + c
    typedef logic [15:0] pattern_t;

    typedef logic [9:0] score_t;

    // Empty box while no piece is in play
    localparam shape_code_t SHAPE_NONE = 5'd31;

    typedef enum logic [2:0] {
        IDLE,
        SPAWN,
        FALLING,
        ROTATE,
        LOCK,
        CLEAR,
        GAMEOVER
    } game_state_t;

    typedef struct packed {
        logic move_left;
        logic move_right;
        logic rot_cw;
        logic rot_ccw;
        logic start;
        logic drop_tick;
    } buttons_t;

    typedef struct packed {
        row_idx_t row;
        col_idx_t col;
    } piece_pos_t;

    typedef struct packed {
        logic floor;
        logic left;
        logic right;
        logic rot_fits;
    } contact_t;

    // =========================================================================
    // Rotation cycles
    // =========================================================================
    function automatic shape_code_t next_orient(input shape_code_t code, input logic ccw);
        shape_code_t nxt;
        nxt = code;
        case (code)
            // I, S and Z have two orientations
            5'd0:  nxt = 5'd7;
            5'd7:  nxt = 5'd0;
            5'd2:  nxt = 5'd9;
            5'd9:  nxt = 5'd2;
            5'd3:  nxt = 5'd8;
            5'd8:  nxt = 5'd3;
            // J
            5'd4:  nxt = ccw ? 5'd12 : 5'd10;
            5'd10: nxt = ccw ? 5'd4  : 5'd11;
            5'd11: nxt = ccw ? 5'd10 : 5'd12;
            5'd12: nxt = ccw ? 5'd11 : 5'd4;
            // L
            5'd5:  nxt = ccw ? 5'd15 : 5'd13;
            5'd13: nxt = ccw ? 5'd5  : 5'd14;
            5'd14: nxt = ccw ? 5'd13 : 5'd15;
            5'd15: nxt = ccw ? 5'd14 : 5'd5;
            // T runs 6, 18, 17, 16 clockwise
            5'd6:  nxt = ccw ? 5'd16 : 5'd18;
            5'd18: nxt = ccw ? 5'd6  : 5'd17;
            5'd17: nxt = ccw ? 5'd18 : 5'd16;
            5'd16: nxt = ccw ? 5'd17 : 5'd6;
            default: nxt = code;
        endcase
        return nxt;
    endfunction

endpackage

`default_nettype wire
